// File: rtl/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Instruction memory depth in words, indexed by pc[9:2]
`define MIPS_IMEM_WORDS 256

// Data memory depth in words, indexed by address[9:2]
`define MIPS_DMEM_WORDS 256

// Architectural registers
`define MIPS_REG_COUNT 32

`endif

// File: rtl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;                   // Data word or byte address
    typedef logic [4:0]  reg_addr_t;               // Register index

    // Instruction [31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // Instruction [5:0], R-type only
    typedef enum logic [5:0] {
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } alu_ctrl_t;

    typedef enum logic [1:0] {SEL_PC_PLUS4, SEL_PC_BRANCH, SEL_PC_JUMP, SEL_PC_JR} sel_pc_t;
    typedef enum logic [1:0] {SEL_RES_MEM, SEL_RES_ALU, SEL_RES_PC8} sel_result_t;
    typedef enum logic [1:0] {SEL_WA_RT, SEL_WA_RD, SEL_WA_RA} sel_wa_t;
    typedef enum logic [1:0] {SEL_FWD_REG, SEL_FWD_WB, SEL_FWD_MEM} sel_fwd_t;

    localparam reg_addr_t REG_RA = 5'd31;          // Link register for jal

endpackage

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  mips_pkg::word_t     a,
    input  mips_pkg::word_t     b,
    input  mips_pkg::alu_ctrl_t sel,
    output mips_pkg::word_t     y,
    output logic                zero
);

    always_comb begin
        case (sel)
            mips_pkg::ALU_ADD: y = a + b;
            mips_pkg::ALU_SUB: y = a - b;
            mips_pkg::ALU_AND: y = a & b;
            mips_pkg::ALU_OR:  y = a | b;
            mips_pkg::ALU_SLT: y = {31'd0, $signed(a) < $signed(b)};   // Signed compare
            default:           y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module regfile (
    input  logic                clock,
    input  logic                reset,
    input  logic                we,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::reg_addr_t ra0,
    input  mips_pkg::reg_addr_t ra1,
    input  mips_pkg::reg_addr_t ra2,            // Debug port
    input  mips_pkg::word_t     wd,
    output mips_pkg::word_t     rd0,
    output mips_pkg::word_t     rd1,
    output mips_pkg::word_t     rd2
);

    mips_pkg::word_t regs [`MIPS_REG_COUNT];
    logic            wr_ok;

    assign wr_ok = we && (wa != '0);                   // r0 stays zero

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write passes straight to the reader
    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t ra);
        if (ra == '0) return '0;
        if (wr_ok && (wa == ra)) return wd;
        return regs[ra];
    endfunction

    always_comb begin
        rd0 = read_port(ra0);
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

// File: rtl/hazard_controller.sv
`timescale 1ns/1ps

module hazard_controller (
    input  mips_pkg::reg_addr_t   d_rs,
    input  mips_pkg::reg_addr_t   d_rt,
    input  mips_pkg::reg_addr_t   e_rs,
    input  mips_pkg::reg_addr_t   e_rt,
    input  mips_pkg::reg_addr_t   m_rf_wa,
    input  mips_pkg::reg_addr_t   w_rf_wa,
    input  logic                  m_rf_we,
    input  logic                  w_rf_we,
    input  mips_pkg::sel_result_t e_sel_result,   // MEM marks a load in execute
    output mips_pkg::sel_fwd_t    sel_forward_alu_a,
    output mips_pkg::sel_fwd_t    sel_forward_alu_b,
    output logic                  f_stall,
    output logic                  d_stall,
    output logic                  e_flush
);

    logic lw_stall;

    // Youngest producer wins, r0 never forwarded
    function automatic mips_pkg::sel_fwd_t pick_fwd(
        input mips_pkg::reg_addr_t src,
        input mips_pkg::reg_addr_t m_wa,
        input mips_pkg::reg_addr_t w_wa,
        input logic                m_we,
        input logic                w_we
    );
        if (src == '0) return mips_pkg::SEL_FWD_REG;
        if (m_we && (m_wa == src)) return mips_pkg::SEL_FWD_MEM;
        if (w_we && (w_wa == src)) return mips_pkg::SEL_FWD_WB;
        return mips_pkg::SEL_FWD_REG;
    endfunction

    assign sel_forward_alu_a = pick_fwd(e_rs, m_rf_wa, w_rf_wa, m_rf_we, w_rf_we);
    assign sel_forward_alu_b = pick_fwd(e_rt, m_rf_wa, w_rf_wa, m_rf_we, w_rf_we);

    // Load result not ready until writeback, so hold one cycle
    assign lw_stall = (e_sel_result == mips_pkg::SEL_RES_MEM) && ((e_rt == d_rs) || (e_rt == d_rt));

    assign f_stall = lw_stall;
    assign d_stall = lw_stall;
    assign e_flush = lw_stall;                         // Bubble into execute

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  mips_pkg::word_t       d_instruction,
    input  logic                  branch,         // beq operands equal
    output logic                  rf_we,
    output logic                  dmem_we,
    output logic                  sel_alu_b,      // 1 picks sign immediate
    output mips_pkg::alu_ctrl_t   alu_ctrl,
    output mips_pkg::sel_result_t sel_result,
    output mips_pkg::sel_wa_t     sel_wa,
    output mips_pkg::sel_pc_t     sel_pc
);

    always_comb begin
        // Nop unless decoded below
        rf_we      = 1'b0;
        dmem_we    = 1'b0;
        sel_alu_b  = 1'b0;
        alu_ctrl   = mips_pkg::ALU_ADD;
        sel_result = mips_pkg::SEL_RES_ALU;              // Never MEM for a nop, hazard reads it
        sel_wa     = mips_pkg::SEL_WA_RT;
        sel_pc     = mips_pkg::SEL_PC_PLUS4;
        case (mips_pkg::opcode_t'(d_instruction[31:26]))
            mips_pkg::OP_RTYPE: begin
                rf_we  = 1'b1;
                sel_wa = mips_pkg::SEL_WA_RD;
                case (mips_pkg::funct_t'(d_instruction[5:0]))
                    mips_pkg::FN_ADD: alu_ctrl = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: alu_ctrl = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: alu_ctrl = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  alu_ctrl = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: alu_ctrl = mips_pkg::ALU_SLT;
                    mips_pkg::FN_JR: begin
                        rf_we  = 1'b0;
                        sel_pc = mips_pkg::SEL_PC_JR;         // Target is rs read in decode
                    end
                    default: rf_we = 1'b0;                    // Unknown funct, nop
                endcase
            end
            mips_pkg::OP_ADDI: begin
                rf_we     = 1'b1;
                sel_alu_b = 1'b1;
            end
            mips_pkg::OP_LW: begin
                rf_we      = 1'b1;
                sel_alu_b  = 1'b1;
                sel_result = mips_pkg::SEL_RES_MEM;
            end
            mips_pkg::OP_SW: begin
                dmem_we   = 1'b1;
                sel_alu_b = 1'b1;
            end
            mips_pkg::OP_BEQ: sel_pc = branch ? mips_pkg::SEL_PC_BRANCH : mips_pkg::SEL_PC_PLUS4;
            mips_pkg::OP_JAL: begin
                // Redirect already done in fetch, only the link write is left
                rf_we      = 1'b1;
                sel_result = mips_pkg::SEL_RES_PC8;
                sel_wa     = mips_pkg::SEL_WA_RA;
            end
            default: ;                                        // j and unknown opcodes
        endcase
    end

endmodule

// File: rtl/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                  clock,
    input  logic                  reset,
    input  mips_pkg::word_t       instruction,
    input  mips_pkg::word_t       dmem_rd,
    input  mips_pkg::reg_addr_t   dbg_ra,
    input  logic                  d_rf_we,          // Decode-stage controls
    input  logic                  d_dmem_we,
    input  logic                  d_sel_alu_b,
    input  mips_pkg::alu_ctrl_t   d_alu_ctrl,
    input  mips_pkg::sel_result_t d_sel_result,
    input  mips_pkg::sel_wa_t     d_sel_wa,
    input  mips_pkg::sel_pc_t     d_sel_pc,
    output mips_pkg::word_t       pc,
    output mips_pkg::word_t       alu_out,
    output mips_pkg::word_t       dmem_wd,
    output logic                  dmem_we,
    output mips_pkg::word_t       d_instruction,
    output logic                  branch,
    output mips_pkg::word_t       dbg_rd
);

    mips_pkg::word_t       pc_plus4, jump_addr, pc_next;          // Fetch
    logic                  f_jump;
    mips_pkg::sel_pc_t     f_sel_pc;
    mips_pkg::word_t       d_pc_plus4, d_rd0, d_rd1, d_sign_imm, branch_addr;   // Decode
    mips_pkg::reg_addr_t   d_rs, d_rt;
    logic                  e_rf_we, e_dmem_we, e_sel_alu_b;       // Execute
    mips_pkg::alu_ctrl_t   e_alu_ctrl;
    mips_pkg::sel_result_t e_sel_result;
    mips_pkg::sel_wa_t     e_sel_wa;
    mips_pkg::word_t       e_rd0, e_rd1, e_sign_imm, e_pc_plus4, alu_a, fwd_b, alu_b, e_alu_y;
    mips_pkg::reg_addr_t   e_rs, e_rt, e_rd, e_rf_wa;
    logic                  m_rf_we;                               // Memory
    mips_pkg::sel_result_t m_sel_result;
    mips_pkg::reg_addr_t   m_rf_wa;
    mips_pkg::word_t       m_pc_plus4;
    logic                  w_rf_we;                               // Writeback
    mips_pkg::sel_result_t w_sel_result;
    mips_pkg::reg_addr_t   w_rf_wa;
    mips_pkg::word_t       w_dmem_rd, w_alu_out, w_pc_plus4, result;
    mips_pkg::sel_fwd_t    sel_forward_alu_a, sel_forward_alu_b;
    logic                  f_stall, d_stall, e_flush;

    hazard_controller u_hazard (
        .d_rs(d_rs), .d_rt(d_rt), .e_rs(e_rs), .e_rt(e_rt),
        .m_rf_wa(m_rf_wa), .w_rf_wa(w_rf_wa), .m_rf_we(m_rf_we), .w_rf_we(w_rf_we),
        .e_sel_result(e_sel_result),
        .sel_forward_alu_a(sel_forward_alu_a), .sel_forward_alu_b(sel_forward_alu_b),
        .f_stall(f_stall), .d_stall(d_stall), .e_flush(e_flush)
    );

    //////////////////////////////////////////////////
    // Fetch
    assign pc_plus4  = pc + 32'd4;
    assign f_jump    = (instruction[31:26] == mips_pkg::OP_J) || (instruction[31:26] == mips_pkg::OP_JAL);
    assign jump_addr = {pc_plus4[31:28], instruction[25:0], 2'b00};
    assign f_sel_pc  = f_jump ? mips_pkg::SEL_PC_JUMP : d_sel_pc;   // j/jal skip decode

    always_comb begin
        case (f_sel_pc)
            mips_pkg::SEL_PC_BRANCH: pc_next = branch_addr;
            mips_pkg::SEL_PC_JUMP:   pc_next = jump_addr;
            mips_pkg::SEL_PC_JR:     pc_next = d_rd0;
            default:                 pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) pc <= '0;
        else if (!f_stall) pc <= pc_next;
    end

    //////////////////////////////////////////////////
    // Decode
    always_ff @(posedge clock) begin
        if (reset) d_instruction <= '0;                // All-zero word decodes as nop
        else if (!d_stall) d_instruction <= instruction;
    end

    always_ff @(posedge clock) begin
        if (!d_stall) d_pc_plus4 <= pc_plus4;
    end

    assign d_rs        = d_instruction[25:21];
    assign d_rt        = d_instruction[20:16];
    assign d_sign_imm  = {{16{d_instruction[15]}}, d_instruction[15:0]};
    assign branch_addr = d_pc_plus4 + {d_sign_imm[29:0], 2'b00};
    assign branch      = (d_instruction[31:26] == mips_pkg::OP_BEQ) && (d_rd0 == d_rd1);

    regfile u_regfile (
        .clock(clock), .reset(reset),
        .we(w_rf_we), .wa(w_rf_wa), .wd(result),       // From writeback
        .ra0(d_rs), .ra1(d_rt), .ra2(dbg_ra),
        .rd0(d_rd0), .rd1(d_rd1), .rd2(dbg_rd)
    );

    //////////////////////////////////////////////////
    // Execute
    always_ff @(posedge clock) begin
        if (reset || e_flush) begin                    // Nop
            e_rf_we      <= 1'b0;
            e_dmem_we    <= 1'b0;
            e_sel_alu_b  <= 1'b0;
            e_alu_ctrl   <= mips_pkg::ALU_ADD;
            e_sel_result <= mips_pkg::SEL_RES_ALU;
            e_sel_wa     <= mips_pkg::SEL_WA_RT;
        end else begin
            e_rf_we      <= d_rf_we;
            e_dmem_we    <= d_dmem_we;
            e_sel_alu_b  <= d_sel_alu_b;
            e_alu_ctrl   <= d_alu_ctrl;
            e_sel_result <= d_sel_result;
            e_sel_wa     <= d_sel_wa;
        end
    end

    always_ff @(posedge clock) begin
        e_rd0      <= d_rd0;
        e_rd1      <= d_rd1;
        e_rs       <= d_rs;
        e_rt       <= d_rt;
        e_rd       <= d_instruction[15:11];
        e_sign_imm <= d_sign_imm;
        e_pc_plus4 <= d_pc_plus4;
    end

    function automatic mips_pkg::word_t fwd_mux(
        input mips_pkg::sel_fwd_t sel,
        input mips_pkg::word_t    rf_val,
        input mips_pkg::word_t    wb_val,
        input mips_pkg::word_t    mem_val
    );
        case (sel)
            mips_pkg::SEL_FWD_MEM: return mem_val;
            mips_pkg::SEL_FWD_WB:  return wb_val;
            default:               return rf_val;
        endcase
    endfunction

    assign alu_a = fwd_mux(sel_forward_alu_a, e_rd0, result, alu_out);
    assign fwd_b = fwd_mux(sel_forward_alu_b, e_rd1, result, alu_out);   // Also store data
    assign alu_b = e_sel_alu_b ? e_sign_imm : fwd_b;

    alu u_alu (.a(alu_a), .b(alu_b), .sel(e_alu_ctrl), .y(e_alu_y), .zero());   // beq in decode

    always_comb begin
        case (e_sel_wa)
            mips_pkg::SEL_WA_RD: e_rf_wa = e_rd;
            mips_pkg::SEL_WA_RA: e_rf_wa = mips_pkg::REG_RA;
            default:             e_rf_wa = e_rt;
        endcase
    end

    //////////////////////////////////////////////////
    // Memory and writeback
    always_ff @(posedge clock) begin
        if (reset) begin
            m_rf_we      <= 1'b0;
            dmem_we      <= 1'b0;
            m_sel_result <= mips_pkg::SEL_RES_ALU;
            w_rf_we      <= 1'b0;
            w_sel_result <= mips_pkg::SEL_RES_ALU;
        end else begin
            m_rf_we      <= e_rf_we;
            dmem_we      <= e_dmem_we;
            m_sel_result <= e_sel_result;
            w_rf_we      <= m_rf_we;
            w_sel_result <= m_sel_result;
        end
    end

    always_ff @(posedge clock) begin
        alu_out    <= e_alu_y;                         // Memory address
        dmem_wd    <= fwd_b;
        m_rf_wa    <= e_rf_wa;
        m_pc_plus4 <= e_pc_plus4;
        w_dmem_rd  <= dmem_rd;
        w_alu_out  <= alu_out;
        w_rf_wa    <= m_rf_wa;
        w_pc_plus4 <= m_pc_plus4;
    end

    always_comb begin
        case (w_sel_result)
            mips_pkg::SEL_RES_MEM: result = w_dmem_rd;
            mips_pkg::SEL_RES_PC8: result = w_pc_plus4 + 32'd4;   // jal link
            default:               result = w_alu_out;
        endcase
    end

    // Fetch and decode must freeze together or an instruction is lost
    assert property (@(posedge clock) disable iff (reset) f_stall == d_stall)
        else $error("Fetch and decode stalls disagree");

endmodule

// File: rtl/mips_memories.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_memories (
    input  logic            clock,
    input  logic            reset,            // Only watched by the load-port check
    input  logic            imem_load_we,
    input  mips_pkg::word_t imem_load_addr,
    input  mips_pkg::word_t imem_load_data,
    input  mips_pkg::word_t pc,
    input  logic            dmem_we,
    input  mips_pkg::word_t dmem_addr,
    input  mips_pkg::word_t dmem_wd,
    output mips_pkg::word_t instruction,
    output mips_pkg::word_t dmem_rd
);

    mips_pkg::word_t imem [`MIPS_IMEM_WORDS];
    mips_pkg::word_t dmem [`MIPS_DMEM_WORDS];

    // Program load port
    always_ff @(posedge clock) begin
        if (imem_load_we) imem[imem_load_addr[9:2]] <= imem_load_data;
    end

    assign instruction = imem[pc[9:2]];              // Combinational fetch

    always_ff @(posedge clock) begin
        if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wd;
    end

    assign dmem_rd = dmem[dmem_addr[9:2]];

    // Program must not change under a running core
    assert property (@(posedge clock) imem_load_we |-> reset)
        else $error("Instruction memory written outside reset");

endmodule

// File: rtl/mips_top.sv
`timescale 1ns/1ps

module mips_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                imem_load_we,
    input  mips_pkg::word_t     imem_load_addr,
    input  mips_pkg::word_t     imem_load_data,
    input  mips_pkg::reg_addr_t dbg_ra,
    output mips_pkg::word_t     dbg_rd,
    output mips_pkg::word_t     pc,
    output logic                dmem_we,
    output mips_pkg::word_t     alu_out,
    output mips_pkg::word_t     dmem_wd
);

    mips_pkg::word_t       instruction, dmem_rd, d_instruction;
    logic                  branch, d_rf_we, d_dmem_we, d_sel_alu_b;
    mips_pkg::alu_ctrl_t   d_alu_ctrl;
    mips_pkg::sel_result_t d_sel_result;
    mips_pkg::sel_wa_t     d_sel_wa;
    mips_pkg::sel_pc_t     d_sel_pc;

    datapath u_datapath (
        .clock(clock), .reset(reset), .instruction(instruction), .dmem_rd(dmem_rd),
        .dbg_ra(dbg_ra), .d_rf_we(d_rf_we), .d_dmem_we(d_dmem_we), .d_sel_alu_b(d_sel_alu_b),
        .d_alu_ctrl(d_alu_ctrl), .d_sel_result(d_sel_result), .d_sel_wa(d_sel_wa),
        .d_sel_pc(d_sel_pc), .pc(pc), .alu_out(alu_out), .dmem_wd(dmem_wd),
        .dmem_we(dmem_we), .d_instruction(d_instruction), .branch(branch), .dbg_rd(dbg_rd)
    );

    control_unit u_control (
        .d_instruction(d_instruction), .branch(branch), .rf_we(d_rf_we),
        .dmem_we(d_dmem_we), .sel_alu_b(d_sel_alu_b), .alu_ctrl(d_alu_ctrl),
        .sel_result(d_sel_result), .sel_wa(d_sel_wa), .sel_pc(d_sel_pc)
    );

    mips_memories u_mem (
        .clock(clock), .reset(reset), .imem_load_we(imem_load_we),
        .imem_load_addr(imem_load_addr), .imem_load_data(imem_load_data), .pc(pc),
        .dmem_we(dmem_we), .dmem_addr(alu_out), .dmem_wd(dmem_wd),
        .instruction(instruction), .dmem_rd(dmem_rd)
    );

endmodule

// File: verification/tb_mips_top.sv
`timescale 1ns/1ps

module tb_mips_top;

    logic                clock;
    logic                reset;
    logic                imem_load_we;
    mips_pkg::word_t     imem_load_addr;
    mips_pkg::word_t     imem_load_data;
    mips_pkg::reg_addr_t dbg_ra;
    mips_pkg::word_t     dbg_rd;
    mips_pkg::word_t     pc;
    logic                dmem_we;
    mips_pkg::word_t     alu_out;
    mips_pkg::word_t     dmem_wd;

    mips_pkg::word_t     prog_addr[$];                 // P lines
    mips_pkg::word_t     prog_word[$];
    mips_pkg::reg_addr_t reg_num[$];                   // R lines
    mips_pkg::word_t     reg_val[$];
    mips_pkg::word_t     store_addr[$];                // S lines, in program order
    mips_pkg::word_t     store_data[$];
    mips_pkg::word_t     halt_addr;
    logic                halt_found;
    logic                run_active;                   // Watchdog armed
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  cycle_limit;
    int                  store_idx;

    mips_top u_dut (
        .clock(clock), .reset(reset), .imem_load_we(imem_load_we),
        .imem_load_addr(imem_load_addr), .imem_load_data(imem_load_data),
        .dbg_ra(dbg_ra), .dbg_rd(dbg_rd), .pc(pc), .dmem_we(dmem_we),
        .alu_out(alu_out), .dmem_wd(dmem_wd)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;                     // 10 ns period
    end

    //////////////////////////////////////////////////
    // Helpers
    task automatic check_value(input string name, input mips_pkg::word_t expected,
                               input mips_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_testdata();
        int              fd;
        int              r;
        string           line;
        mips_pkg::word_t a;
        mips_pkg::word_t v;
        fd = $fopen("verification/mips_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/mips_testdata.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            void'($fgets(line, fd));
            if ($sscanf(line, "P %h %h", a, v) == 2) begin
                prog_addr.push_back(a);
                prog_word.push_back(v);
                // j to its own address marks the end of the program
                if (v[31:26] == 6'h02 && {a[31:28], v[25:0], 2'b00} == a) begin
                    halt_addr  = a;
                    halt_found = 1'b1;
                end
            end else if ($sscanf(line, "R %d %h", r, v) == 2) begin
                reg_num.push_back(mips_pkg::reg_addr_t'(r));
                reg_val.push_back(v);
            end else if ($sscanf(line, "S %h %h", a, v) == 2) begin
                store_addr.push_back(a);
                store_data.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    task automatic load_program();
        foreach (prog_addr[i]) begin
            @(posedge clock);
            imem_load_we   <= 1'b1;
            imem_load_addr <= prog_addr[i];
            imem_load_data <= prog_word[i];
        end
        @(posedge clock);
        imem_load_we <= 1'b0;
    endtask

    task automatic read_back_regs();
        int order[$];
        int j;
        int tmp;
        for (int i = 0; i < reg_num.size(); i++) order.push_back(i);
        for (int i = order.size() - 1; i > 0; i--) begin   // Shuffle
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            @(posedge clock);
            dbg_ra <= reg_num[order[k]];
            @(negedge clock);                          // Read port settled
            check_value($sformatf("r%0d", reg_num[order[k]]), reg_val[order[k]], dbg_rd);
        end
    endtask

    //////////////////////////////////////////////////
    // Store port and watchdog
    always @(negedge clock) begin
        if (!reset && dmem_we) begin
            if (store_idx < store_addr.size()) begin
                check_value($sformatf("store%0d_addr", store_idx), store_addr[store_idx], alu_out);
                check_value($sformatf("store%0d_data", store_idx), store_data[store_idx], dmem_wd);
            end else begin
                $display("Store to %h with data %h was not expected", alu_out, dmem_wd);
                errors++;
            end
            store_idx++;
        end
    end

    always @(posedge clock) begin
        if (run_active) begin
            cycles <= cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("Timeout after %0d cycles, pc %h never reached the halt loop",
                         cycle_limit, pc);
                $display(">>> FAIL");
                $finish;
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(47));
        reset          = 1'b1;
        imem_load_we   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        dbg_ra         = '0;
        halt_addr      = '0;
        halt_found     = 1'b0;
        run_active     = 1'b0;
        errors         = 0;
        checks         = 0;
        cycles         = 0;
        store_idx      = 0;
        read_testdata();
        cycle_limit = 4 * prog_word.size() + 50;
        load_program();                                // Under reset
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("reset_pc", 32'd0, pc);
        check_value("reset_dmem_we", 32'd0, {31'd0, dmem_we});
        if (halt_found) begin
            run_active = 1'b1;
            while (pc != halt_addr) @(negedge clock);
            run_active = 1'b0;
            repeat (10) @(negedge clock);              // Drain the pipeline
            read_back_regs();
        end else begin
            $display("Program has no halt loop, nothing was run");
            errors++;
        end
        if (store_idx != store_addr.size()) begin
            $display("Saw %0d stores, program has %0d", store_idx, store_addr.size());
            errors++;
        end
        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verification/mips_testdata.txt
# P <byte address hex> <instruction hex>   R <register dec> <expected value hex>
# S <store address hex> <store data hex>, in the order the stores happen
P 00000000 20010005   # addi r1, r0, 5
P 00000004 2002FFFD   # addi r2, r0, -3
P 00000008 2003000C   # addi r3, r0, 12
P 0000000C 00232822   # sub  r5, r1, r3
P 00000010 00233024   # and  r6, r1, r3
P 00000014 00233825   # or   r7, r1, r3
P 00000018 0041402A   # slt  r8, r2, r1
P 0000001C 0022482A   # slt  r9, r1, r2
P 00000020 00235020   # add  r10, r1, r3
P 00000024 014A5820   # add  r11, r10, r10
P 00000028 016A6022   # sub  r12, r11, r10
P 0000002C 218D0064   # addi r13, r12, 100
P 00000030 200E0040   # addi r14, r0, 0x40
P 00000034 ADCD0000   # sw   r13, 0(r14)
P 00000038 8DCF0000   # lw   r15, 0(r14)
P 0000003C 01E18020   # add  r16, r15, r1
P 00000040 ADD00004   # sw   r16, 4(r14)
P 00000044 11ED0003   # beq  r15, r13, +3 (taken)
P 00000048 20110001   # addi r17, r0, 1 (delay slot)
P 0000004C 20120001   # addi r18, r0, 1 (skipped)
P 00000050 20120002   # addi r18, r0, 2 (skipped)
P 00000054 10230001   # beq  r1, r3, +1 (not taken)
P 00000058 20130007   # addi r19, r0, 7
P 0000005C 20140009   # addi r20, r0, 9
P 00000060 0C000020   # jal  0x80
P 00000064 20150001   # addi r21, r0, 1 (never runs)
P 00000068 20160055   # addi r22, r0, 0x55
P 0000006C 0800001B   # j    0x6c (halt)
P 00000080 20170003   # addi r23, r0, 3
P 00000084 02F7C020   # add  r24, r23, r23
P 00000088 03E0C825   # or   r25, r31, r0
P 0000008C 03E00008   # jr   r31
P 00000090 00000000   # nop
S 00000040 00000075
S 00000044 0000007A
R 0 00000000
R 1 00000005
R 2 FFFFFFFD
R 3 0000000C
R 5 FFFFFFF9
R 6 00000004
R 7 0000000D
R 8 00000001
R 9 00000000
R 10 00000011
R 11 00000022
R 12 00000011
R 13 00000075
R 14 00000040
R 15 00000075
R 16 0000007A
R 17 00000001
R 18 00000000
R 19 00000007
R 20 00000009
R 21 00000000
R 22 00000055
R 23 00000003
R 24 00000006
R 25 00000068
R 31 00000068

// File: verilog.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/hazard_controller.sv
rtl/control_unit.sv
rtl/datapath.sv
rtl/mips_memories.sv
rtl/mips_top.sv
verification/tb_mips_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_mips_top -o sim_mips \
    && ./obj_dir/sim_mips | tee /dev/stderr | grep -F ">>> PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
